/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert --timescale 1ns/1ps -j 0
TOP       = tb_decoding_graph
FILELIST  = build.f
BUILD_DIR = obj_dir
LOG       = sim.log
PASS_MSG  = Test OK

SOURCES = $(wildcard source/*.sv) $(wildcard dv/*.sv) $(wildcard dv/*.svh)

.PHONY: all compile run clean

all: run

compile: $(BUILD_DIR)/V$(TOP)

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -qx "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* build.f */
+incdir+dv
source/decoder_pkg.sv
source/neighbor_link.sv
source/processing_unit.sv
source/unit_array.sv
source/stage_controller.sv
source/decoding_graph.sv
dv/tb_decoding_graph.sv

/* dv/tb_cases.svh */
`ifndef TB_CASES_SVH
`define TB_CASES_SVH

// Entry c of each array belongs to case c.
// Rounds are listed in send order, one bit per unit of a round at x*Z+z.
// Roots are listed in address order, u*X*Z + x*Z + z
localparam int NUM_CASES = 7;

string case_names [NUM_CASES] = '{
    "no_defects",
    "single_corner",
    "adjacent_pair",
    "cleared_after_pair",
    "single_top",
    "vertical_pair",
    "bridged_pair"
};

int case_rounds [NUM_CASES][GRID_WIDTH_U] = '{
    '{'h000, 'h000},
    '{'h001, 'h000},  // Defect at address 0
    '{'h180, 'h000},  // Neighbours 7 and 8 in the first round
    '{'h000, 'h000},  // Nothing left over from the pair
    '{'h000, 'h010},  // Centre of the top layer, address 13
    '{'h020, 'h021},  // 5 below 14, plus a lone defect at 9
    '{'h041, 'h000}   // 0 and 6 meet through 3
};

int case_roots [NUM_CASES][PU_COUNT] = '{
    '{0, 1, 2, 3, 4, 5, 6, 7, 8, 9, 10, 11, 12, 13, 14, 15, 16, 17},
    '{0, 0, 2, 0, 4, 5, 6, 7, 8, 0, 10, 11, 12, 13, 14, 15, 16, 17},
    '{0, 1, 2, 3, 4, 4, 4, 4, 4, 9, 10, 11, 12, 13, 14, 15, 4, 4},
    '{0, 1, 2, 3, 4, 5, 6, 7, 8, 9, 10, 11, 12, 13, 14, 15, 16, 17},
    '{0, 1, 2, 3, 4, 5, 6, 7, 8, 9, 4, 11, 4, 4, 4, 15, 4, 17},
    // Two clusters, {0,9,10,12} and {2,4,5,8,11,13,14,17}
    '{0, 1, 2, 3, 2, 2, 6, 7, 2, 0, 0, 2, 0, 2, 2, 15, 16, 2},
    '{0, 0, 2, 0, 4, 5, 0, 0, 8, 0, 10, 11, 12, 13, 14, 0, 16, 17}
};

`endif

/* dv/tb_decoding_graph.sv */
`timescale 1ns/1ps

module tb_decoding_graph;

    localparam int GRID_WIDTH_X = 3;
    localparam int GRID_WIDTH_Z = 3;
    localparam int GRID_WIDTH_U = 2;
    localparam int MAX_WEIGHT   = 2;
    localparam int GROWTH_STEPS = 2;
    localparam int MEAS_WIDTH   = GRID_WIDTH_X * GRID_WIDTH_Z;
    localparam int PU_COUNT     = MEAS_WIDTH * GRID_WIDTH_U;
    localparam int ADDR_WIDTH   = (PU_COUNT > 1) ? $clog2(PU_COUNT) : 1;

    localparam int RESET_CYCLES = 5;
    localparam int MAX_GAP      = 3;  // Idle cycles before a round
    localparam int SEED         = 32'h37f52038;

    `include "tb_cases.svh"

    // Longest path through the grid bounds the merge length
    localparam int DIAMETER    = (GRID_WIDTH_X - 1) + (GRID_WIDTH_Z - 1) + (GRID_WIDTH_U - 1);
    localparam int CASE_CYCLES = GRID_WIDTH_U * (MAX_GAP + 2) +
                                 GROWTH_STEPS * (DIAMETER + 3) + 1 + GRID_WIDTH_U;
    localparam int TIMEOUT_CYCLES = RESET_CYCLES + 2 * NUM_CASES * CASE_CYCLES + 20;

    logic                           clk = 1'b0;
    logic                           reset;
    logic                           meas_valid;
    logic [MEAS_WIDTH-1:0]          measurements;
    logic                           credit;
    logic                           result_valid;
    logic [PU_COUNT*ADDR_WIDTH-1:0] roots;
    logic [PU_COUNT*ADDR_WIDTH-1:0] captured_roots;

    int credits;           // Held by the source
    int credit_pulses;     // Since the last result
    int rounds_sent;       // In the current case
    int current_case;
    int last_result_case;
    int results_seen;
    int cycle_count;
    bit result_ready;
    int root_errors;
    int credit_errors;
    int protocol_errors;

    decoding_graph #(
        .GRID_WIDTH_X(GRID_WIDTH_X),
        .GRID_WIDTH_Z(GRID_WIDTH_Z),
        .GRID_WIDTH_U(GRID_WIDTH_U),
        .MAX_WEIGHT(MAX_WEIGHT),
        .GROWTH_STEPS(GROWTH_STEPS)
    ) decoding_graph_i (
        .clk(clk),
        .reset(reset),
        .meas_valid_i(meas_valid),
        .measurements_i(measurements),
        .credit_o(credit),
        .result_valid_o(result_valid),
        .roots_o(roots)
    );

    always #4 clk = ~clk;

    task automatic check_credit_return(input string name);
        assert (credit_pulses == GRID_WIDTH_U) else begin
            $display("ERR %s credit pulses: expected %0d, actual %0d",
                     name, GRID_WIDTH_U, credit_pulses);
            credit_errors++;
        end
    endtask

    // One clock; outputs are sampled at the falling edge, where they are stable
    task automatic advance_cycle();
        @(negedge clk);
        if (credit) begin
            credits++;
            credit_pulses++;
            assert (credits <= GRID_WIDTH_U) else begin
                $display("Decoder returned a credit that was never spent");
                protocol_errors++;
            end
        end
        if (result_valid) begin
            assert (rounds_sent == GRID_WIDTH_U) else begin
                $display("result_valid_o came after only %0d of %0d rounds in case %s",
                         rounds_sent, GRID_WIDTH_U, case_names[current_case]);
                protocol_errors++;
            end
            if (results_seen > 0) begin
                check_credit_return(case_names[last_result_case]);
            end
            credit_pulses    = 0;
            results_seen++;
            last_result_case = current_case;
            captured_roots   = roots;
            result_ready     = 1'b1;
        end
    endtask

    task automatic check_roots(input int c);
        int got;
        for (int idx = 0; idx < PU_COUNT; idx++) begin
            got = int'(captured_roots[idx*ADDR_WIDTH +: ADDR_WIDTH]);
            assert (got == case_roots[c][idx]) else begin
                $display("ERR %s unit %0d: expected root %0d, actual %0d",
                         case_names[c], idx, case_roots[c][idx], got);
                root_errors++;
            end
        end
    endtask

    task automatic run_case(input int c);
        int gap;
        current_case = c;
        rounds_sent  = 0;
        result_ready = 1'b0;
        for (int r = 0; r < GRID_WIDTH_U; r++) begin
            gap = int'($urandom_range(MAX_GAP, 0));
            repeat (gap) advance_cycle();
            while (credits == 0) begin
                advance_cycle();  // Hold until a credit comes back
            end
            meas_valid   = 1'b1;
            measurements = MEAS_WIDTH'(case_rounds[c][r]);
            credits--;
            rounds_sent++;
            advance_cycle();
            meas_valid   = 1'b0;
        end
        while (!result_ready) begin
            advance_cycle();
        end
        check_roots(c);
    endtask

    initial begin
        cycle_count = 0;
        while (cycle_count < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("Test FAILED");
        $finish;
    end

    initial begin
        void'($urandom(SEED));
        reset           = 1'b1;
        meas_valid      = 1'b0;
        measurements    = '0;
        credits         = GRID_WIDTH_U;
        credit_pulses   = 0;
        rounds_sent     = 0;
        current_case    = 0;
        results_seen    = 0;
        root_errors     = 0;
        credit_errors   = 0;
        protocol_errors = 0;
        repeat (RESET_CYCLES) @(negedge clk);
        reset = 1'b0;

        assert (!credit && !result_valid) else begin
            $display("credit_o or result_valid_o is high right after reset");
            protocol_errors++;
        end

        for (int c = 0; c < NUM_CASES; c++) begin
            run_case(c);
        end

        // Last credits, then a few idle cycles to catch extra pulses
        while (credits < GRID_WIDTH_U) begin
            advance_cycle();
        end
        repeat (4) advance_cycle();
        check_credit_return(case_names[last_result_case]);

        $display("Errors: %0d root, %0d credit, %0d protocol",
                 root_errors, credit_errors, protocol_errors);
        if (root_errors + credit_errors + protocol_errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

/* source/decoder_pkg.sv */
package decoder_pkg;

    // Decoder stage, driven by the stage controller to every unit and link
    typedef enum logic [2:0] {
        STAGE_IDLE   = 3'd0,
        STAGE_LOAD   = 3'd1,
        STAGE_GROW   = 3'd2,
        STAGE_MERGE  = 3'd3,
        STAGE_REPORT = 3'd4,
        STAGE_CREDIT = 3'd5
    } stage_t;

    // Regular grid, one neighbour on each side of the three axes
    localparam int NEIGHBOR_COUNT = 6;

    // Slot indices in the per-unit neighbour vectors
    localparam int DIR_NORTH = 0;  // x - 1
    localparam int DIR_SOUTH = 1;  // x + 1
    localparam int DIR_WEST  = 2;  // z - 1
    localparam int DIR_EAST  = 3;  // z + 1
    localparam int DIR_DOWN  = 4;  // Previous round
    localparam int DIR_UP    = 5;  // Next round

    // Grown length of one edge.
    // Two bits hold MAX_WEIGHT up to 3, the edge is fully grown at MAX_WEIGHT
    typedef logic [1:0] growth_t;

endpackage

/* source/decoding_graph.sv */
`timescale 1ns/1ps

module decoding_graph #(
    parameter int GRID_WIDTH_X = 3,
    parameter int GRID_WIDTH_Z = 3,
    parameter int GRID_WIDTH_U = 2,
    parameter int MAX_WEIGHT   = 2,
    parameter int GROWTH_STEPS = 2,
    localparam int PU_COUNT    = GRID_WIDTH_X * GRID_WIDTH_Z * GRID_WIDTH_U,
    localparam int ADDR_WIDTH  = (PU_COUNT > 1) ? $clog2(PU_COUNT) : 1
) (
    input  logic                                 clk,
    input  logic                                 reset,
    input  logic                                 meas_valid_i,
    input  logic [GRID_WIDTH_X*GRID_WIDTH_Z-1:0] measurements_i,
    output logic                                 credit_o,
    output logic                                 result_valid_o,
    output logic [PU_COUNT*ADDR_WIDTH-1:0]       roots_o
);
    import decoder_pkg::*;

    stage_t stage;
    logic   shift;      // Round accepted this cycle
    logic   any_busy;   // Some root still moving

    stage_controller #(
        .GRID_WIDTH_U(GRID_WIDTH_U),
        .GROWTH_STEPS(GROWTH_STEPS)
    ) stage_controller_i (
        .clk(clk),
        .reset(reset),
        .meas_valid_i(meas_valid_i),
        .any_busy_i(any_busy),
        .stage_o(stage),
        .shift_o(shift),
        .credit_o(credit_o),
        .result_valid_o(result_valid_o)
    );

    unit_array #(
        .GRID_WIDTH_X(GRID_WIDTH_X),
        .GRID_WIDTH_Z(GRID_WIDTH_Z),
        .GRID_WIDTH_U(GRID_WIDTH_U),
        .MAX_WEIGHT(MAX_WEIGHT),
        .ADDR_WIDTH(ADDR_WIDTH)
    ) unit_array_i (
        .clk(clk),
        .reset(reset),
        .stage_i(stage),
        .shift_i(shift),
        .measurements_i(measurements_i),
        .roots_o(roots_o),
        .any_busy_o(any_busy)
    );

endmodule

/* source/neighbor_link.sv */
`timescale 1ns/1ps

module neighbor_link #(
    parameter int MAX_WEIGHT = 2
) (
    input  logic                clk,
    input  logic                reset,
    input  decoder_pkg::stage_t stage_i,
    input  logic                a_active_i,
    input  logic                b_active_i,
    output logic                fully_grown_o
);
    import decoder_pkg::*;

    localparam growth_t FULL_LENGTH = growth_t'(MAX_WEIGHT);

    growth_t    count_q;
    logic [2:0] grown_sum;  // Count plus both endpoints, up to 5

    // Each active endpoint grows the edge by one
    assign grown_sum = {1'b0, count_q} + 3'(a_active_i) + 3'(b_active_i);

    always_ff @(posedge clk) begin
        if (reset) begin
            count_q <= '0;
        end else if (stage_i == STAGE_IDLE || stage_i == STAGE_LOAD) begin
            count_q <= '0;  // Fresh edge for the next decode
        end else if (stage_i == STAGE_GROW) begin
            if (grown_sum >= 3'(MAX_WEIGHT)) begin
                count_q <= FULL_LENGTH;
            end else begin
                count_q <= grown_sum[1:0];
            end
        end
    end

    assign fully_grown_o = (count_q == FULL_LENGTH);

endmodule

/* source/processing_unit.sv */
`timescale 1ns/1ps

module processing_unit #(
    parameter int                    ADDR_WIDTH = 5,
    parameter logic [ADDR_WIDTH-1:0] PU_ADDRESS = '0
) (
    input  logic                                                clk,
    input  logic                                                reset,
    input  decoder_pkg::stage_t                                 stage_i,
    input  logic                                                shift_i,
    input  logic                                                measurement_i,
    output logic                                                measurement_o,
    input  logic [decoder_pkg::NEIGHBOR_COUNT-1:0][ADDR_WIDTH-1:0] neighbor_root_i,
    input  logic [decoder_pkg::NEIGHBOR_COUNT-1:0]              neighbor_grown_i,
    output logic                                                active_o,
    output logic [ADDR_WIDTH-1:0]                               root_o,
    output logic                                                busy_o
);
    import decoder_pkg::*;

    logic                  defect_q;
    logic                  active_q;
    logic [ADDR_WIDTH-1:0] root_q;
    logic                  busy_q;
    logic [ADDR_WIDTH-1:0] min_root;
    logic                  any_grown;

    // Smallest root over this unit and every fully grown edge
    always_comb begin
        min_root = root_q;
        for (int d = 0; d < NEIGHBOR_COUNT; d++) begin
            if (neighbor_grown_i[d] && (neighbor_root_i[d] < min_root)) begin
                min_root = neighbor_root_i[d];
            end
        end
    end

    assign any_grown = |neighbor_grown_i;

    // Measurement shift stage
    always_ff @(posedge clk) begin
        if (shift_i) begin
            defect_q <= measurement_i;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            root_q   <= PU_ADDRESS;
            active_q <= 1'b0;
            busy_q   <= 1'b0;
        end else if (shift_i) begin
            // New round arriving, restart as a lone vertex
            root_q   <= PU_ADDRESS;
            active_q <= measurement_i;
            busy_q   <= 1'b0;
        end else begin
            case (stage_i)
                STAGE_LOAD: begin
                    root_q   <= PU_ADDRESS;
                    active_q <= defect_q;
                    busy_q   <= 1'b0;
                end
                STAGE_GROW: begin
                    busy_q <= 1'b1;  // Keeps the first MERGE cycle open
                end
                STAGE_MERGE: begin
                    root_q   <= min_root;
                    active_q <= active_q | any_grown;  // Joined a cluster
                    busy_q   <= (min_root != root_q);
                end
                default: begin
                    busy_q <= 1'b0;
                end
            endcase
        end
    end

    assign measurement_o = defect_q;
    assign active_o      = active_q;
    assign root_o        = root_q;
    assign busy_o        = busy_q;

endmodule

/* source/stage_controller.sv */
`timescale 1ns/1ps

module stage_controller #(
    parameter int GRID_WIDTH_U = 2,
    parameter int GROWTH_STEPS = 2
) (
    input  logic                clk,
    input  logic                reset,
    input  logic                meas_valid_i,
    input  logic                any_busy_i,
    output decoder_pkg::stage_t stage_o,
    output logic                shift_o,
    output logic                credit_o,
    output logic                result_valid_o
);
    import decoder_pkg::*;

    localparam int CNT_WIDTH  = $clog2(GRID_WIDTH_U + 1);
    localparam int STEP_WIDTH = $clog2(GROWTH_STEPS + 1);

    stage_t                stage_q;
    stage_t                stage_d;
    logic [CNT_WIDTH-1:0]  round_q;       // Rounds held in the array
    logic [CNT_WIDTH-1:0]  round_d;
    logic [STEP_WIDTH-1:0] step_q;        // Growth iteration
    logic [STEP_WIDTH-1:0] step_d;
    logic [CNT_WIDTH-1:0]  credit_cnt_q;  // Credits handed back so far
    logic [CNT_WIDTH-1:0]  credit_cnt_d;
    logic                  credit_q;
    logic                  result_valid_q;

    // A returned credit may be spent before the CREDIT stage is over,
    // so rounds are also taken while credits are still going out
    assign shift_o = meas_valid_i &&
                     (stage_q == STAGE_IDLE || stage_q == STAGE_LOAD ||
                      stage_q == STAGE_CREDIT);

    always_comb begin
        stage_d      = stage_q;
        round_d      = round_q + CNT_WIDTH'(shift_o);
        step_d       = step_q;
        credit_cnt_d = credit_cnt_q;

        case (stage_q)
            STAGE_IDLE,
            STAGE_LOAD: begin
                if (round_d == CNT_WIDTH'(GRID_WIDTH_U)) begin
                    // Array full, start the first growth step
                    stage_d = STAGE_GROW;
                    round_d = '0;
                    step_d  = '0;
                end else if (round_d != '0) begin
                    stage_d = STAGE_LOAD;
                end
            end
            STAGE_GROW: begin
                stage_d = STAGE_MERGE;  // One growth cycle per step
            end
            STAGE_MERGE: begin
                // First quiet cycle closes the merge
                if (!any_busy_i) begin
                    if (step_q == STEP_WIDTH'(GROWTH_STEPS - 1)) begin
                        stage_d = STAGE_REPORT;
                    end else begin
                        stage_d = STAGE_GROW;
                        step_d  = step_q + 1'b1;
                    end
                end
            end
            STAGE_REPORT: begin
                stage_d      = STAGE_CREDIT;
                credit_cnt_d = '0;
            end
            STAGE_CREDIT: begin
                if (credit_cnt_q == CNT_WIDTH'(GRID_WIDTH_U - 1)) begin
                    stage_d = STAGE_IDLE;
                end else begin
                    credit_cnt_d = credit_cnt_q + 1'b1;
                end
            end
            default: begin
                stage_d = STAGE_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            stage_q        <= STAGE_IDLE;
            round_q        <= '0;
            step_q         <= '0;
            credit_cnt_q   <= '0;
            credit_q       <= 1'b0;
            result_valid_q <= 1'b0;
        end else begin
            stage_q        <= stage_d;
            round_q        <= round_d;
            step_q         <= step_d;
            credit_cnt_q   <= credit_cnt_d;
            credit_q       <= (stage_d == STAGE_CREDIT);  // One credit per CREDIT cycle
            result_valid_q <= (stage_d == STAGE_REPORT);
        end
    end

    assign stage_o        = stage_q;
    assign credit_o       = credit_q;
    assign result_valid_o = result_valid_q;

endmodule

/* source/unit_array.sv */
`timescale 1ns/1ps

module unit_array #(
    parameter int GRID_WIDTH_X = 3,
    parameter int GRID_WIDTH_Z = 3,
    parameter int GRID_WIDTH_U = 2,
    parameter int MAX_WEIGHT   = 2,
    parameter int ADDR_WIDTH   = 5
) (
    input  logic                                                        clk,
    input  logic                                                        reset,
    input  decoder_pkg::stage_t                                         stage_i,
    input  logic                                                        shift_i,
    input  logic [GRID_WIDTH_X*GRID_WIDTH_Z-1:0]                        measurements_i,
    output logic [GRID_WIDTH_X*GRID_WIDTH_Z*GRID_WIDTH_U*ADDR_WIDTH-1:0] roots_o,
    output logic                                                        any_busy_o
);
    import decoder_pkg::*;

    localparam int PER_ROUND = GRID_WIDTH_X * GRID_WIDTH_Z;
    localparam int PU_COUNT  = PER_ROUND * GRID_WIDTH_U;

    logic [PU_COUNT-1:0][ADDR_WIDTH-1:0] root;
    logic [PU_COUNT-1:0]                 active;
    logic [PU_COUNT-1:0]                 busy;
    logic [PU_COUNT-1:0]                 meas_out;
    logic [2:0][PU_COUNT-1:0]            grown_hi;  // Edge to the upper neighbour per axis

    for (genvar u = 0; u < GRID_WIDTH_U; u++) begin : g_u
        for (genvar x = 0; x < GRID_WIDTH_X; x++) begin : g_x
            for (genvar z = 0; z < GRID_WIDTH_Z; z++) begin : g_z
                localparam int IDX = u * PER_ROUND + x * GRID_WIDTH_Z + z;

                logic [NEIGHBOR_COUNT-1:0][ADDR_WIDTH-1:0] nbr_root;
                logic [NEIGHBOR_COUNT-1:0]                 nbr_grown;
                logic                                      meas_in;

                // Rounds enter at the top layer and move down
                if (u == GRID_WIDTH_U - 1) begin : g_top
                    assign meas_in = measurements_i[x * GRID_WIDTH_Z + z];
                end else begin : g_chain
                    assign meas_in = meas_out[IDX + PER_ROUND];
                end

                // Axis 0 is x, 1 is z, 2 is u
                for (genvar a = 0; a < 3; a++) begin : g_axis
                    localparam int POS    = (a == 0) ? x : (a == 1) ? z : u;
                    localparam int SIZE   = (a == 0) ? GRID_WIDTH_X :
                                            (a == 1) ? GRID_WIDTH_Z : GRID_WIDTH_U;
                    localparam int STRIDE = (a == 0) ? GRID_WIDTH_Z : (a == 1) ? 1 : PER_ROUND;
                    localparam int LO_DIR = (a == 0) ? DIR_NORTH : (a == 1) ? DIR_WEST : DIR_DOWN;
                    localparam int HI_DIR = (a == 0) ? DIR_SOUTH : (a == 1) ? DIR_EAST : DIR_UP;

                    if (POS > 0) begin : g_lo
                        assign nbr_root[LO_DIR]  = root[IDX - STRIDE];
                        assign nbr_grown[LO_DIR] = grown_hi[a][IDX - STRIDE];
                    end else begin : g_lo_edge
                        assign nbr_root[LO_DIR]  = root[IDX];  // Never grown
                        assign nbr_grown[LO_DIR] = 1'b0;
                    end

                    // Each unit owns the edge toward its upper neighbour
                    if (POS < SIZE - 1) begin : g_hi
                        assign nbr_root[HI_DIR]  = root[IDX + STRIDE];
                        assign nbr_grown[HI_DIR] = grown_hi[a][IDX];

                        neighbor_link #(
                            .MAX_WEIGHT(MAX_WEIGHT)
                        ) link_i (
                            .clk(clk),
                            .reset(reset),
                            .stage_i(stage_i),
                            .a_active_i(active[IDX]),
                            .b_active_i(active[IDX + STRIDE]),
                            .fully_grown_o(grown_hi[a][IDX])
                        );
                    end else begin : g_hi_edge
                        assign nbr_root[HI_DIR]  = root[IDX];
                        assign nbr_grown[HI_DIR] = 1'b0;
                        assign grown_hi[a][IDX]  = 1'b0;
                    end
                end

                processing_unit #(
                    .ADDR_WIDTH(ADDR_WIDTH),
                    .PU_ADDRESS(ADDR_WIDTH'(IDX))
                ) pu_i (
                    .clk(clk),
                    .reset(reset),
                    .stage_i(stage_i),
                    .shift_i(shift_i),
                    .measurement_i(meas_in),
                    .measurement_o(meas_out[IDX]),
                    .neighbor_root_i(nbr_root),
                    .neighbor_grown_i(nbr_grown),
                    .active_o(active[IDX]),
                    .root_o(root[IDX]),
                    .busy_o(busy[IDX])
                );
            end
        end
    end

    assign roots_o    = root;   // Address order
    assign any_busy_o = |busy;

endmodule
